//--- filelist.f
source/cpu_defs_pkg.sv
source/bus_defs_pkg.sv
source/data_bus_if.sv
source/pipe_reg.sv
source/ctrl.sv
source/id.sv
source/ex.sv
source/mem.sv
source/wishbone_bus.sv
source/openmips_lite.sv
tests/openmips_lite_properties.sv
tests/openmips_lite_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= openmips_lite_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^No errors$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/openmips_lite_tb.sv
`timescale 1ns/1ps

module openmips_lite_tb;

	localparam logic [31:0] RESET_PC = 32'hbfc0_0000;
	localparam int MAX_PROG = 64;
	localparam int CLK_NS = 20;

	logic        clk;
	logic        rst_n_i;
	logic [31:0] rom_data_i;
	logic [31:0] rom_addr_o;
	logic        rom_ce_o;
	logic [31:0] wishbone_addr_o;
	logic [31:0] wishbone_data_o;
	logic        wishbone_we_o;
	logic [3:0]  wishbone_sel_o;
	logic        wishbone_stb_o;
	logic        wishbone_cyc_o;
	logic [31:0] wishbone_data_i;
	logic        wishbone_ack_i;

	logic [31:0] prog [0:MAX_PROG-1];
	string       prog_tag [0:MAX_PROG-1];
	int          prog_len = 0;
	logic [7:0]  ram [0:255];

	// expected stores from the reference and observed stores from the slave
	logic [31:0] exp_addr [$];
	logic [3:0]  exp_sel [$];
	logic [31:0] exp_data [$];
	string       exp_tag [$];
	logic [31:0] obs_addr [$];
	logic [3:0]  obs_sel [$];
	logic [31:0] obs_data [$];

	int          errors = 0;
	int          checked = 0;
	int          exp_total = 0;
	logic [31:0] rnd = 32'hb956;
	int          wait_cnt = -1;

	openmips_lite #(.RESET_PC(RESET_PC)) dut0 (.*);

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 37) ^ 8'hc3;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input logic [31:0] w, input string tag);
		prog[prog_len] = w;
		prog_tag[prog_len] = tag;
		prog_len++;
	endtask

	task automatic load_program();
		// dependent ALU chain with results stored back to back
		emit(enc_i(6'h0d, 0, 1, 16'h1234), "alu_chain");
		emit(enc_i(6'h0d, 0, 2, 16'h00f0), "alu_chain");
		emit(enc_r(1, 2, 3, 6'h21), "alu_chain");
		emit(enc_r(3, 2, 4, 6'h23), "alu_chain");
		emit(enc_r(3, 1, 5, 6'h24), "alu_chain");
		emit(enc_r(5, 2, 6, 6'h25), "alu_chain");
		emit(enc_r(6, 3, 7, 6'h26), "alu_chain");
		emit(enc_r(4, 7, 8, 6'h2a), "alu_chain");
		emit(enc_i(6'h0f, 0, 9, 16'h8001), "alu_chain");
		emit(enc_r(9, 1, 10, 6'h2a), "alu_chain");
		emit(enc_i(6'h09, 9, 11, 16'hffff), "alu_chain");
		emit(enc_i(6'h2b, 0, 3, 16'h0080), "alu_chain");
		emit(enc_i(6'h2b, 0, 4, 16'h0084), "alu_chain");
		emit(enc_i(6'h2b, 0, 5, 16'h0088), "alu_chain");
		emit(enc_i(6'h2b, 0, 6, 16'h008c), "alu_chain");
		emit(enc_i(6'h2b, 0, 7, 16'h0090), "alu_chain");
		emit(enc_i(6'h2b, 0, 8, 16'h0094), "alu_chain");
		emit(enc_i(6'h2b, 0, 9, 16'h0098), "alu_chain");
		emit(enc_i(6'h2b, 0, 10, 16'h009c), "alu_chain");
		emit(enc_i(6'h2b, 0, 11, 16'h00a0), "alu_chain");
		emit(enc_i(6'h23, 0, 12, 16'h0084), "load_use");
		emit(enc_r(12, 1, 13, 6'h21), "load_use");
		emit(enc_i(6'h2b, 0, 13, 16'h00a4), "load_use");
		// one byte to every lane and then sign extension
		emit(enc_i(6'h0d, 0, 14, 16'h00a5), "byte_access");
		emit(enc_i(6'h28, 0, 14, 16'h00b0), "byte_access");
		emit(enc_i(6'h28, 0, 14, 16'h00b5), "byte_access");
		emit(enc_i(6'h28, 0, 14, 16'h00ba), "byte_access");
		emit(enc_i(6'h28, 0, 14, 16'h00bf), "byte_access");
		emit(enc_i(6'h20, 0, 15, 16'h00b5), "byte_access");
		emit(enc_i(6'h2b, 0, 15, 16'h00c0), "byte_access");
		emit(enc_i(6'h0d, 0, 0, 16'h7777), "reg_zero");
		emit(enc_r(1, 2, 0, 6'h21), "reg_zero");
		emit(enc_i(6'h2b, 0, 0, 16'h00c4), "reg_zero");
		emit(enc_i(6'h23, 0, 16, 16'h0010), "backpressure");
		emit(enc_i(6'h20, 0, 17, 16'h0013), "backpressure");
		emit(enc_r(16, 17, 18, 6'h21), "backpressure");
		emit(enc_i(6'h2b, 0, 18, 16'h00c8), "backpressure");
		emit(enc_i(6'h2b, 0, 17, 16'h00cc), "backpressure");
	endtask

	// instruction set model run once before the DUT starts
	function automatic void iss_run();
		logic [31:0] r [0:31];
		logic [7:0]  m [0:255];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		logic [31:0] res;
		logic [7:0]  base;
		logic [1:0]  off;
		logic [3:0]  sel;
		int          wr;
		for (int k = 0; k < 32; k++)
			r[k] = '0;
		for (int k = 0; k < 256; k++)
			m[k] = fill_byte(k);
		for (int i = 0; i < prog_len; i++) begin
			w = prog[i];
			a = r[w[25:21]];
			b = r[w[20:16]];
			ea = a + {{16{w[15]}}, w[15:0]};
			base = {ea[7:2], 2'b00};
			off = ea[1:0];
			wr = int'(w[20:16]);
			res = '0;
			case (w[31:26])
				6'h00: begin
					wr = int'(w[15:11]);
					case (w[5:0])
						6'h21: res = a + b;
						6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = -1;
					endcase
				end
				6'h0d: res = a | {16'h0000, w[15:0]};
				6'h09: res = ea;
				6'h0f: res = {w[15:0], 16'h0000};
				6'h23: res = {m[base + 8'd3], m[base + 8'd2], m[base + 8'd1], m[base]};
				6'h20: res = {{24{m[ea[7:0]][7]}}, m[ea[7:0]]};
				6'h2b: begin
					wr = -1;
					for (int l = 0; l < 4; l++)
						m[base + 8'(l)] = b[8*l +: 8];
					exp_addr.push_back(ea);
					exp_sel.push_back(4'hf);
					exp_data.push_back(b);
					exp_tag.push_back(prog_tag[i]);
				end
				6'h28: begin
					wr = -1;
					m[ea[7:0]] = b[7:0];
					sel = '0;
					sel[off] = 1'b1;
					exp_addr.push_back(ea);
					exp_sel.push_back(sel);
					// only the selected lane is compared
					exp_data.push_back({4{b[7:0]}});
					exp_tag.push_back(prog_tag[i]);
				end
				default: wr = -1;
			endcase
			if (wr > 0)
				r[wr] = res;
		end
	endfunction

	function automatic logic [31:0] rom_word(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - RESET_PC) >> 2;
		if (idx < 32'(prog_len))
			return prog[idx];
		return 32'h0;
	endfunction

	assign rom_data_i = rom_word(rom_addr_o);

	task automatic check_store(input logic [31:0] addr, input logic [3:0] sel,
		input logic [31:0] data);
		logic [31:0] mask;
		assert (checked < exp_total) else begin
			$display("store to %h was not expected from the program", addr);
			errors++;
		end
		if (checked < exp_total) begin
			for (int l = 0; l < 4; l++)
				mask[8*l +: 8] = {8{exp_sel[checked][l]}};
			assert (addr == exp_addr[checked]) else begin
				$display("ERR %s addr expected %h actual %h", exp_tag[checked],
					exp_addr[checked], addr);
				errors++;
			end
			assert (sel == exp_sel[checked]) else begin
				$display("ERR %s sel expected %h actual %h", exp_tag[checked],
					exp_sel[checked], sel);
				errors++;
			end
			assert ((data & mask) == (exp_data[checked] & mask)) else begin
				$display("ERR %s data expected %h actual %h", exp_tag[checked],
					exp_data[checked] & mask, data & mask);
				errors++;
			end
		end
		checked++;
	endtask

	task automatic serve_access();
		logic [7:0] base;
		base = {wishbone_addr_o[7:2], 2'b00};
		if (wishbone_we_o) begin
			for (int l = 0; l < 4; l++)
				if (wishbone_sel_o[l])
					ram[base + 8'(l)] = wishbone_data_o[8*l +: 8];
			obs_addr.push_back(wishbone_addr_o);
			obs_sel.push_back(wishbone_sel_o);
			obs_data.push_back(wishbone_data_o);
		end else begin
			wishbone_data_i = {ram[base + 8'd3], ram[base + 8'd2], ram[base + 8'd1], ram[base]};
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// slave with a random ack delay of 0 to 5 cycles
	initial begin
		for (int k = 0; k < 256; k++)
			ram[k] = fill_byte(k);
		forever begin
			@(posedge clk);
			#2;
			if (wishbone_ack_i) begin
				wishbone_ack_i = 1'b0;
				wait_cnt = -1;
			end else if (wishbone_stb_o && wishbone_cyc_o) begin
				if (wait_cnt < 0) begin
					rnd = xorshift(rnd);
					wait_cnt = int'(rnd % 32'd6);
				end
				if (wait_cnt == 0) begin
					serve_access();
					wishbone_ack_i = 1'b1;
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	// compare process
	initial begin
		forever begin
			@(posedge clk);
			#3;
			while (obs_addr.size() > 0)
				check_store(obs_addr.pop_front(), obs_sel.pop_front(), obs_data.pop_front());
		end
	end

	initial begin
		#1;
		repeat (prog_len * 12 + 20) @(posedge clk);
		$display("timeout, program did not finish, %0d of %0d stores seen", checked, exp_total);
		$display("Errors found");
		$finish;
	end

	initial begin
		rst_n_i = 1'b0;
		wishbone_data_i = '0;
		wishbone_ack_i = 1'b0;
		load_program();
		iss_run();
		exp_total = exp_addr.size();
		repeat (2) @(posedge clk);
		#1;
		assert (!wishbone_cyc_o && !wishbone_stb_o && !wishbone_we_o && !rom_ce_o) else begin
			$display("bus or fetch enable active during reset");
			errors++;
		end
		#1;
		rst_n_i = 1'b1;
		@(posedge clk);
		#1;
		assert (rom_addr_o == RESET_PC) else begin
			$display("ERR reset expected %h actual %h", RESET_PC, rom_addr_o);
			errors++;
		end
		assert (rom_ce_o) else begin
			$display("fetch not enabled in the first cycle after reset");
			errors++;
		end
		while (checked < exp_total)
			@(posedge clk);
		// extra stores would show up here
		repeat (40) @(posedge clk);
		$display("stores checked %0d of %0d, errors %0d", checked, exp_total, errors);
		if (errors == 0 && checked == exp_total)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- tests/openmips_lite_properties.sv
`timescale 1ns/1ps

module openmips_lite_properties (
	input logic                   clk,
	input logic                   rst_n_i,
	input logic [31:0]            wishbone_addr_o,
	input logic [31:0]            wishbone_data_o,
	input bus_defs_pkg::bus_sel_t wishbone_sel_o,
	input logic                   wishbone_stb_o,
	input logic                   wishbone_cyc_o,
	input logic                   wishbone_ack_i,
	input bus_defs_pkg::bus_state_e state
);

	stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
		wishbone_stb_o |-> wishbone_cyc_o)
		else $error("stb high without cyc");

	// request held until the slave acks
	req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		wishbone_stb_o && !wishbone_ack_i |=> wishbone_stb_o && $stable(wishbone_addr_o) &&
		$stable(wishbone_data_o) && $stable(wishbone_sel_o))
		else $error("request changed before ack");

	reset_idle: assert property (@(posedge clk)
		!rst_n_i |=> !wishbone_stb_o && !wishbone_cyc_o)
		else $error("stb or cyc high after reset");

	done_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		state == bus_defs_pkg::BUS_DONE |-> !wishbone_stb_o)
		else $error("stb high in done state");

endmodule

bind wishbone_bus openmips_lite_properties props0 (.*);

//--- source/openmips_lite.sv
`timescale 1ns/1ps

module openmips_lite #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic [31:0]                         rom_data_i,
	output logic [31:0]                         rom_addr_o,
	output logic                                rom_ce_o,
	output logic [bus_defs_pkg::BUS_ADDR_W-1:0] wishbone_addr_o,
	output logic [bus_defs_pkg::BUS_DATA_W-1:0] wishbone_data_o,
	output logic                                wishbone_we_o,
	output bus_defs_pkg::bus_sel_t              wishbone_sel_o,
	output logic                                wishbone_stb_o,
	output logic                                wishbone_cyc_o,
	input  logic [bus_defs_pkg::BUS_DATA_W-1:0] wishbone_data_i,
	input  logic                                wishbone_ack_i
);

	logic [4:0]  stall;
	logic        stallreq_id;
	logic        stallreq_bus;
	logic        ex_is_load;
	logic [31:0] fetch_pc;

	cpu_defs_pkg::if_id_t  if_d;
	cpu_defs_pkg::if_id_t  if_q;
	cpu_defs_pkg::id_ex_t  id_d;
	cpu_defs_pkg::id_ex_t  id_q;
	cpu_defs_pkg::ex_mem_t ex_d;
	cpu_defs_pkg::ex_mem_t ex_q;
	cpu_defs_pkg::mem_wb_t mem_d;
	cpu_defs_pkg::mem_wb_t mem_q;

	data_bus_if data_bus0 ();

	ctrl #(.RESET_PC(RESET_PC)) ctrl0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stallreq_id_i(stallreq_id),
		.stallreq_bus_i(stallreq_bus),
		.stall_o(stall),
		.pc_o(fetch_pc),
		.rom_ce_o(rom_ce_o)
	);

	assign rom_addr_o = fetch_pc;
	// nothing fetched before the ROM is enabled
	assign if_d = '{pc: fetch_pc, inst: rom_ce_o ? rom_data_i : 32'h0};

	pipe_reg #(.payload_t(cpu_defs_pkg::if_id_t)) if_id0 (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall[2:1]), .d_i(if_d), .q_o(if_q)
	);

	id id0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.if_id_i(if_q),
		.ex_fwd_i(ex_d),
		.ex_is_load_i(ex_is_load),
		.mem_fwd_i(mem_d),
		.wb_i(mem_q),
		.id_ex_o(id_d),
		.stallreq_o(stallreq_id)
	);

	pipe_reg #(.payload_t(cpu_defs_pkg::id_ex_t)) id_ex0 (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall[3:2]), .d_i(id_d), .q_o(id_q)
	);

	ex ex0 (
		.id_ex_i(id_q),
		.ex_mem_o(ex_d),
		.is_load_o(ex_is_load)
	);

	pipe_reg #(.payload_t(cpu_defs_pkg::ex_mem_t)) ex_mem0 (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall[4:3]), .d_i(ex_d), .q_o(ex_q)
	);

	mem mem0 (
		.ex_mem_i(ex_q),
		.bus(data_bus0.stage),
		.mem_wb_o(mem_d)
	);

	// WB never stalls
	pipe_reg #(.payload_t(cpu_defs_pkg::mem_wb_t)) mem_wb0 (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i({1'b0, stall[4]}), .d_i(mem_d), .q_o(mem_q)
	);

	wishbone_bus wishbone_bus0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.bus(data_bus0.master),
		.wishbone_addr_o(wishbone_addr_o),
		.wishbone_data_o(wishbone_data_o),
		.wishbone_we_o(wishbone_we_o),
		.wishbone_sel_o(wishbone_sel_o),
		.wishbone_stb_o(wishbone_stb_o),
		.wishbone_cyc_o(wishbone_cyc_o),
		.wishbone_data_i(wishbone_data_i),
		.wishbone_ack_i(wishbone_ack_i),
		.stallreq_o(stallreq_bus)
	);

endmodule

//--- source/wishbone_bus.sv
`timescale 1ns/1ps

module wishbone_bus (
	input  logic                                clk,
	input  logic                                rst_n_i,
	data_bus_if.master                          bus,
	output logic [bus_defs_pkg::BUS_ADDR_W-1:0] wishbone_addr_o,
	output logic [bus_defs_pkg::BUS_DATA_W-1:0] wishbone_data_o,
	output logic                                wishbone_we_o,
	output bus_defs_pkg::bus_sel_t              wishbone_sel_o,
	output logic                                wishbone_stb_o,
	output logic                                wishbone_cyc_o,
	input  logic [bus_defs_pkg::BUS_DATA_W-1:0] wishbone_data_i,
	input  logic                                wishbone_ack_i,
	output logic                                stallreq_o
);

	bus_defs_pkg::bus_state_e            state;
	logic [bus_defs_pkg::BUS_DATA_W-1:0] rdata_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state <= bus_defs_pkg::BUS_IDLE;
			wishbone_cyc_o <= 1'b0;
			wishbone_stb_o <= 1'b0;
			wishbone_we_o <= 1'b0;
		end else begin
			case (state)
				bus_defs_pkg::BUS_IDLE: begin
					if (bus.ce) begin
						state <= bus_defs_pkg::BUS_BUSY;
						wishbone_cyc_o <= 1'b1;
						wishbone_stb_o <= 1'b1;
						wishbone_we_o <= bus.we;
					end
				end
				bus_defs_pkg::BUS_BUSY: begin
					if (wishbone_ack_i) begin
						state <= bus_defs_pkg::BUS_DONE;
						wishbone_cyc_o <= 1'b0;
						wishbone_stb_o <= 1'b0;
						wishbone_we_o <= 1'b0;
					end
				end
				default: state <= bus_defs_pkg::BUS_IDLE;
			endcase
		end
	end

	// request fields and read data
	always_ff @(posedge clk) begin
		if (state == bus_defs_pkg::BUS_IDLE && bus.ce) begin
			wishbone_addr_o <= bus.addr;
			wishbone_data_o <= bus.wdata;
			wishbone_sel_o <= bus.sel;
		end
		if (state == bus_defs_pkg::BUS_BUSY && wishbone_ack_i)
			rdata_q <= wishbone_data_i;
	end

	assign bus.rdata = rdata_q;
	assign bus.done = state == bus_defs_pkg::BUS_DONE;
	// released in the done cycle so MEM moves on exactly once
	assign stallreq_o = (state == bus_defs_pkg::BUS_IDLE && bus.ce) ||
		state == bus_defs_pkg::BUS_BUSY;

endmodule

//--- source/mem.sv
`timescale 1ns/1ps

module mem (
	input  cpu_defs_pkg::ex_mem_t ex_mem_i,
	data_bus_if.stage             bus,
	output cpu_defs_pkg::mem_wb_t mem_wb_o
);

	logic [1:0]                          lane;
	logic                                is_load;
	logic [bus_defs_pkg::BUS_DATA_W-1:0] shifted;
	logic [7:0]                          load_byte;

	assign lane = ex_mem_i.result[1:0];
	assign is_load = (ex_mem_i.mem_op == cpu_defs_pkg::MEM_LW) ||
		(ex_mem_i.mem_op == cpu_defs_pkg::MEM_LB);

	// little-endian lanes, byte 0 on bits 7:0
	always_comb begin
		bus.ce = ex_mem_i.mem_op != cpu_defs_pkg::MEM_NONE;
		bus.we = (ex_mem_i.mem_op == cpu_defs_pkg::MEM_SW) ||
			(ex_mem_i.mem_op == cpu_defs_pkg::MEM_SB);
		bus.addr = ex_mem_i.result;
		bus.sel = 4'b1111;
		bus.wdata = ex_mem_i.store_data;
		if (ex_mem_i.mem_op == cpu_defs_pkg::MEM_SB || ex_mem_i.mem_op == cpu_defs_pkg::MEM_LB)
			bus.sel = 4'b0001 << lane;
		if (ex_mem_i.mem_op == cpu_defs_pkg::MEM_SB)
			bus.wdata = {24'h000000, ex_mem_i.store_data[7:0]} << {lane, 3'b000};
	end

	assign shifted = bus.rdata >> {lane, 3'b000};
	assign load_byte = shifted[7:0];

	always_comb begin
		mem_wb_o.dest = ex_mem_i.dest;
		// a load writes back only once its data is in
		mem_wb_o.wreg = ex_mem_i.wreg && (!is_load || bus.done);
		if (ex_mem_i.mem_op == cpu_defs_pkg::MEM_LB)
			mem_wb_o.wdata = {{24{load_byte[7]}}, load_byte};
		else if (ex_mem_i.mem_op == cpu_defs_pkg::MEM_LW)
			mem_wb_o.wdata = bus.rdata;
		else
			mem_wb_o.wdata = ex_mem_i.result;
	end

endmodule

//--- source/ex.sv
`timescale 1ns/1ps

module ex (
	input  cpu_defs_pkg::id_ex_t  id_ex_i,
	output cpu_defs_pkg::ex_mem_t ex_mem_o,
	output logic                  is_load_o
);

	logic [cpu_defs_pkg::REG_W-1:0] a;
	logic [cpu_defs_pkg::REG_W-1:0] b;
	logic [cpu_defs_pkg::REG_W-1:0] result;

	assign a = id_ex_i.op1;
	assign b = id_ex_i.op2;

	// loads and stores come in as add, result is the address
	always_comb begin
		case (id_ex_i.alu_op)
			cpu_defs_pkg::ALU_ADD: result = a + b;
			cpu_defs_pkg::ALU_SUB: result = a - b;
			cpu_defs_pkg::ALU_AND: result = a & b;
			cpu_defs_pkg::ALU_OR:  result = a | b;
			cpu_defs_pkg::ALU_XOR: result = a ^ b;
			cpu_defs_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			cpu_defs_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
			default:               result = '0;
		endcase
	end

	always_comb begin
		ex_mem_o.result = result;
		ex_mem_o.store_data = id_ex_i.store_data;
		ex_mem_o.mem_op = id_ex_i.mem_op;
		ex_mem_o.dest = id_ex_i.dest;
		ex_mem_o.wreg = id_ex_i.wreg;
	end

	assign is_load_o = (id_ex_i.mem_op == cpu_defs_pkg::MEM_LW) ||
		(id_ex_i.mem_op == cpu_defs_pkg::MEM_LB);

endmodule

//--- source/id.sv
`timescale 1ns/1ps

module id (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  cpu_defs_pkg::if_id_t  if_id_i,
	input  cpu_defs_pkg::ex_mem_t ex_fwd_i,
	input  logic                  ex_is_load_i,
	input  cpu_defs_pkg::mem_wb_t mem_fwd_i,
	input  cpu_defs_pkg::mem_wb_t wb_i,
	output cpu_defs_pkg::id_ex_t  id_ex_o,
	output logic                  stallreq_o
);

	logic [cpu_defs_pkg::REG_W-1:0] regs [0:31];

	cpu_defs_pkg::opcode_e               opcode;
	cpu_defs_pkg::funct_e                funct;
	logic [cpu_defs_pkg::REG_ADDR_W-1:0] rs;
	logic [cpu_defs_pkg::REG_ADDR_W-1:0] rt;
	logic [cpu_defs_pkg::REG_ADDR_W-1:0] rd;
	logic [cpu_defs_pkg::REG_W-1:0]      imm;
	logic [cpu_defs_pkg::REG_W-1:0]      rs_val;
	logic [cpu_defs_pkg::REG_W-1:0]      rt_val;
	logic                                re1;
	logic                                re2;
	logic                                use_imm;

	assign opcode = cpu_defs_pkg::opcode_e'(if_id_i.inst[31:26]);
	assign funct = cpu_defs_pkg::funct_e'(if_id_i.inst[5:0]);
	assign rs = if_id_i.inst[25:21];
	assign rt = if_id_i.inst[20:16];
	assign rd = if_id_i.inst[15:11];

	// r0 reads zero, newest producer wins
	function automatic logic [cpu_defs_pkg::REG_W-1:0] read_reg(
		input logic [cpu_defs_pkg::REG_ADDR_W-1:0] a
	);
		if (a == '0)
			return '0;
		else if (ex_fwd_i.wreg && ex_fwd_i.dest == a)
			return ex_fwd_i.result;
		else if (mem_fwd_i.wreg && mem_fwd_i.dest == a)
			return mem_fwd_i.wdata;
		else if (wb_i.wreg && wb_i.dest == a)
			return wb_i.wdata;
		else
			return regs[a];
	endfunction

	always_ff @(posedge clk) begin
		if (rst_n_i && wb_i.wreg && wb_i.dest != '0)
			regs[wb_i.dest] <= wb_i.wdata;
	end

	always_comb begin
		id_ex_o = '0;
		re1 = 1'b0;
		re2 = 1'b0;
		use_imm = 1'b1;
		imm = {{16{if_id_i.inst[15]}}, if_id_i.inst[15:0]};
		id_ex_o.dest = rt;
		case (opcode)
			cpu_defs_pkg::OP_SPECIAL: begin
				re1 = 1'b1;
				re2 = 1'b1;
				use_imm = 1'b0;
				id_ex_o.dest = rd;
				id_ex_o.wreg = 1'b1;
				case (funct)
					cpu_defs_pkg::FN_ADDU: id_ex_o.alu_op = cpu_defs_pkg::ALU_ADD;
					cpu_defs_pkg::FN_SUBU: id_ex_o.alu_op = cpu_defs_pkg::ALU_SUB;
					cpu_defs_pkg::FN_AND:  id_ex_o.alu_op = cpu_defs_pkg::ALU_AND;
					cpu_defs_pkg::FN_OR:   id_ex_o.alu_op = cpu_defs_pkg::ALU_OR;
					cpu_defs_pkg::FN_XOR:  id_ex_o.alu_op = cpu_defs_pkg::ALU_XOR;
					cpu_defs_pkg::FN_SLT:  id_ex_o.alu_op = cpu_defs_pkg::ALU_SLT;
					default:               id_ex_o.wreg = 1'b0;
				endcase
			end
			cpu_defs_pkg::OP_ORI: begin
				re1 = 1'b1;
				imm = {16'h0000, if_id_i.inst[15:0]};
				id_ex_o.alu_op = cpu_defs_pkg::ALU_OR;
				id_ex_o.wreg = 1'b1;
			end
			cpu_defs_pkg::OP_ADDIU: begin
				re1 = 1'b1;
				id_ex_o.alu_op = cpu_defs_pkg::ALU_ADD;
				id_ex_o.wreg = 1'b1;
			end
			cpu_defs_pkg::OP_LUI: begin
				imm = {16'h0000, if_id_i.inst[15:0]};
				id_ex_o.alu_op = cpu_defs_pkg::ALU_LUI;
				id_ex_o.wreg = 1'b1;
			end
			cpu_defs_pkg::OP_LW, cpu_defs_pkg::OP_LB: begin
				re1 = 1'b1;
				id_ex_o.alu_op = cpu_defs_pkg::ALU_ADD;
				id_ex_o.wreg = 1'b1;
				id_ex_o.mem_op = (opcode == cpu_defs_pkg::OP_LW) ?
					cpu_defs_pkg::MEM_LW : cpu_defs_pkg::MEM_LB;
			end
			cpu_defs_pkg::OP_SW, cpu_defs_pkg::OP_SB: begin
				re1 = 1'b1;
				re2 = 1'b1;
				id_ex_o.alu_op = cpu_defs_pkg::ALU_ADD;
				id_ex_o.mem_op = (opcode == cpu_defs_pkg::OP_SW) ?
					cpu_defs_pkg::MEM_SW : cpu_defs_pkg::MEM_SB;
			end
			default: begin
				id_ex_o.wreg = 1'b0;
			end
		endcase
		rs_val = read_reg(rs);
		rt_val = read_reg(rt);
		id_ex_o.op1 = rs_val;
		id_ex_o.op2 = use_imm ? imm : rt_val;
		id_ex_o.store_data = rt_val;
	end

	// load data is not ready until the load leaves MEM
	assign stallreq_o = ex_is_load_i && ex_fwd_i.wreg && ex_fwd_i.dest != '0 &&
		((re1 && ex_fwd_i.dest == rs) || (re2 && ex_fwd_i.dest == rt));

endmodule

//--- source/ctrl.sv
`timescale 1ns/1ps

module ctrl #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        stallreq_id_i,
	input  logic        stallreq_bus_i,
	output logic [4:0]  stall_o,
	output logic [31:0] pc_o,
	output logic        rom_ce_o
);

	// stall bits: pc, if, id, ex, mem from bit 0 up
	always_comb begin
		if (stallreq_bus_i)
			stall_o = 5'b11111;
		else if (stallreq_id_i)
			stall_o = 5'b00111;
		else
			stall_o = 5'b00000;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rom_ce_o <= 1'b0;
			pc_o <= RESET_PC;
		end else begin
			rom_ce_o <= 1'b1;
			if (rom_ce_o && !stall_o[0])
				pc_o <= pc_o + 32'd4;
		end
	end

endmodule

//--- source/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic       clk,
	input  logic       rst_n_i,
	// bit 0 own stage, bit 1 next stage
	input  logic [1:0] stall_i,
	input  payload_t   d_i,
	output payload_t   q_o
);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			q_o <= '0;
		end else if (stall_i[0] && !stall_i[1]) begin
			// next stage moves on without us
			q_o <= '0;
		end else if (!stall_i[0]) begin
			q_o <= d_i;
		end
	end

endmodule

//--- source/data_bus_if.sv
`timescale 1ns/1ps

interface data_bus_if;

	logic                                ce;
	logic                                we;
	logic [bus_defs_pkg::BUS_ADDR_W-1:0] addr;
	logic [bus_defs_pkg::BUS_DATA_W-1:0] wdata;
	bus_defs_pkg::bus_sel_t              sel;
	logic [bus_defs_pkg::BUS_DATA_W-1:0] rdata;
	// high for one cycle when rdata is valid
	logic                                done;

	modport stage (
		output ce, we, addr, wdata, sel,
		input  rdata, done
	);

	modport master (
		input  ce, we, addr, wdata, sel,
		output rdata, done
	);

endinterface

//--- source/bus_defs_pkg.sv
package bus_defs_pkg;

	localparam int BUS_ADDR_W = 32;
	localparam int BUS_DATA_W = 32;

	// one bit per byte lane
	typedef logic [BUS_DATA_W/8-1:0] bus_sel_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_BUSY,
		BUS_DONE
	} bus_state_e;

endpackage

//--- source/cpu_defs_pkg.sv
package cpu_defs_pkg;

	localparam int REG_W = 32;
	localparam int REG_ADDR_W = 5;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_ADDIU   = 6'b001001,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_LB      = 6'b100000,
		OP_LW      = 6'b100011,
		OP_SB      = 6'b101000,
		OP_SW      = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	// MEM_NONE must stay zero, a cleared payload is a bubble
	typedef enum logic [2:0] {
		MEM_NONE,
		MEM_LW,
		MEM_LB,
		MEM_SW,
		MEM_SB
	} mem_op_e;

	typedef struct packed {
		logic [REG_W-1:0] pc;
		logic [REG_W-1:0] inst;
	} if_id_t;

	typedef struct packed {
		alu_op_e                alu_op;
		mem_op_e                mem_op;
		logic [REG_W-1:0]       op1;
		logic [REG_W-1:0]       op2;
		logic [REG_W-1:0]       store_data;
		logic [REG_ADDR_W-1:0]  dest;
		logic                   wreg;
	} id_ex_t;

	typedef struct packed {
		logic [REG_W-1:0]       result;
		logic [REG_W-1:0]       store_data;
		mem_op_e                mem_op;
		logic [REG_ADDR_W-1:0]  dest;
		logic                   wreg;
	} ex_mem_t;

	typedef struct packed {
		logic [REG_W-1:0]       wdata;
		logic [REG_ADDR_W-1:0]  dest;
		logic                   wreg;
	} mem_wb_t;

endpackage
